// ==== flist.f ====
lookup_pkg.sv
ctrl_pkg.sv
tbl_wr_if.sv
cam_lookup_if.sv
ctrl_writer.sv
key_cam.sv
action_ram.sv
lookup_ctrl.sv
lookup_engine.sv
tb_lookup_engine.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lookup_engine -f flist.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb_lookup_engine.sv ====
//**************************************************************************
// testbench for the match-action lookup stage
// fills the tables over the control stream, checks lookups against a
// shadow model and checks that foreign packets pass through unchanged
//**************************************************************************

`timescale 1ns/1ps

module tb_lookup_engine;
    localparam int DEPTH   = 16;
    localparam int STAGE   = 0;
    localparam int LKID    = 2;
    localparam int TIMEOUT = 20;

    logic                clk;
    logic                rst_n;
    lookup_pkg::key_t    extract_key;
    lookup_pkg::key_t    extract_mask;
    logic                key_valid;
    lookup_pkg::phv_t    phv_in;
    lookup_pkg::action_t action;
    logic                action_valid;
    lookup_pkg::phv_t    phv_out;
    ctrl_pkg::data_t     c_s_tdata;
    ctrl_pkg::user_t     c_s_tuser;
    ctrl_pkg::keep_t     c_s_tkeep;
    logic                c_s_tvalid;
    logic                c_s_tlast;
    ctrl_pkg::data_t     c_m_tdata;
    ctrl_pkg::user_t     c_m_tuser;
    ctrl_pkg::keep_t     c_m_tkeep;
    logic                c_m_tvalid;
    logic                c_m_tlast;

    // shadow copy of both tables
    lookup_pkg::key_t    sh_key [DEPTH];
    logic                sh_vld [DEPTH];
    lookup_pkg::action_t sh_act [DEPTH];

    // pending lookups in issue order
    lookup_pkg::action_t exp_act_q[$];
    lookup_pkg::phv_t    exp_phv_q[$];
    int                  exp_lat_q[$];
    string               exp_name_q[$];
    ctrl_pkg::data_t     val_q[$];
    ctrl_pkg::data_t     beat_q[$];

    int val_errs   = 0;
    int other_errs = 0;

    lookup_engine #(
        .STAGE_ID    (STAGE),
        .LOOKUP_ID   (LKID),
        .TABLE_DEPTH (DEPTH)
    ) lookup_engine_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_action(input string name, input lookup_pkg::action_t exp,
                                input lookup_pkg::action_t act);
        if (act !== exp) begin
            $display("FAIL %s: action expected %h, actual %h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_phv(input string name, input lookup_pkg::phv_t exp,
                             input lookup_pkg::phv_t act);
        if (act !== exp) begin
            $display("FAIL %s: phv expected %h, actual %h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_data(input string name, input ctrl_pkg::data_t exp,
                              input ctrl_pkg::data_t act);
        if (act !== exp) begin
            $display("FAIL %s: tdata expected %h, actual %h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_user(input string name, input ctrl_pkg::user_t exp,
                              input ctrl_pkg::user_t act);
        if (act !== exp) begin
            $display("FAIL %s: tuser expected %h, actual %h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_keep(input string name, input ctrl_pkg::keep_t exp,
                              input ctrl_pkg::keep_t act);
        if (act !== exp) begin
            $display("FAIL %s: tkeep expected %h, actual %h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAIL %s: latency expected %0d, actual %0d", name, exp, act);
            val_errs++;
        end
    endtask

    function automatic ctrl_pkg::data_t byte_swap(input ctrl_pkg::data_t v);
        ctrl_pkg::data_t r;
        for (int b = 0; b < 8; b++) begin
            r[8*b +: 8] = v[8*(7-b) +: 8];
        end
        return r;
    endfunction

    function automatic ctrl_pkg::data_t make_hdr(input logic [15:0] flag, input int stage,
                                                 input int lkid, input int tbl, input int idx);
        ctrl_pkg::data_t h;
        h        = {$urandom, $urandom};
        h[15:0]  = flag;
        h[23:19] = stage[4:0];
        h[18:16] = lkid[2:0];
        h[27:24] = tbl[3:0];
        h[39:32] = idx[7:0];
        return h;
    endfunction

    // lowest valid entry that agrees on all unmasked bits
    function automatic lookup_pkg::action_t ref_lookup(input lookup_pkg::key_t key,
                                                       input lookup_pkg::key_t mask,
                                                       output logic hit);
        hit = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (sh_vld[i] && ((sh_key[i] & ~mask) == (key & ~mask))) begin
                hit = 1'b1;
                return sh_act[i];
            end
        end
        return lookup_pkg::DEFAULT_ACTION;
    endfunction

    // drives beat_q, fwd says whether the beats must reappear on c_m
    task automatic send_pkt(input string name, input logic fwd);
        ctrl_pkg::user_t u;
        ctrl_pkg::keep_t k;
        for (int i = 0; i < beat_q.size(); i++) begin
            u          = ctrl_pkg::user_t'($urandom);
            k          = ctrl_pkg::keep_t'($urandom);
            c_s_tdata  = beat_q[i];
            c_s_tuser  = u;
            c_s_tkeep  = k;
            c_s_tvalid = 1'b1;
            c_s_tlast  = (i == beat_q.size() - 1);
            @(posedge clk);
            #1;
            check_bit({name, " tvalid"}, fwd, c_m_tvalid);
            if (fwd) begin
                check_data(name, beat_q[i], c_m_tdata);
                check_user(name, u, c_m_tuser);
                check_keep(name, k, c_m_tkeep);
                check_bit({name, " tlast"}, c_s_tlast, c_m_tlast);
            end
        end
        c_s_tvalid = 1'b0;
        c_s_tlast  = 1'b0;
        @(posedge clk);
        #1;
        check_bit({name, " idle tvalid"}, 1'b0, c_m_tvalid);
    endtask

    // consumed packet built from val_q, shadow follows the write rule
    task automatic write_table(input string name, input int tbl, input int start);
        int a;
        beat_q.delete();
        beat_q.push_back(make_hdr(16'hf2f1, STAGE, LKID, tbl, start));
        for (int i = 0; i < val_q.size(); i++) begin
            beat_q.push_back(byte_swap(val_q[i]));
            a = (start + i) % DEPTH;
            if (tbl == 0) begin
                sh_key[a] = val_q[i][31:0];
                sh_vld[a] = 1'b1;
            end else begin
                sh_act[a] = val_q[i][47:0];
            end
        end
        send_pkt(name, 1'b0);
    endtask

    task automatic send_foreign(input string name, input ctrl_pkg::data_t hdr, input int n);
        beat_q.delete();
        beat_q.push_back(hdr);
        for (int i = 0; i < n; i++) begin
            beat_q.push_back({$urandom, $urandom});
        end
        send_pkt(name, 1'b1);
    endtask

    task automatic do_lookup(input string name, input lookup_pkg::key_t key,
                             input lookup_pkg::key_t mask);
        logic                hit;
        lookup_pkg::action_t exp;
        lookup_pkg::phv_t    phv;
        int                  n;
        phv = {$urandom, $urandom};
        exp = ref_lookup(key, mask, hit);
        exp_act_q.push_back(exp);
        exp_lat_q.push_back(hit ? 3 : 2);
        exp_phv_q.push_back(phv);
        exp_name_q.push_back(name);
        extract_key  = key;
        extract_mask = mask;
        phv_in       = phv;
        key_valid    = 1'b1;
        @(posedge clk);
        #1;
        key_valid = 1'b0;
        // phv_out must keep the value from the key cycle
        phv_in = {$urandom, $urandom};
        n = 0;
        while (exp_act_q.size() > 0 && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_act_q.size() > 0) begin
            $display("lookup %s was still pending after %0d cycles", name, TIMEOUT);
            other_errs++;
        end
        @(posedge clk);
        #1;
    endtask

    // compare process, sampled mid-cycle
    initial begin : compare_proc
        int waited;
        forever begin
            @(negedge clk);
            if (exp_act_q.size() == 0) begin
                if (rst_n && action_valid) begin
                    $display("action_valid went high with no lookup pending");
                    other_errs++;
                end
            end else begin
                waited = 0;
                while (!action_valid && waited < TIMEOUT) begin
                    @(negedge clk);
                    waited++;
                end
                if (!action_valid) begin
                    $display("lookup %s never raised action_valid", exp_name_q[0]);
                    other_errs++;
                end else begin
                    check_action(exp_name_q[0], exp_act_q[0], action);
                    check_phv(exp_name_q[0], exp_phv_q[0], phv_out);
                    check_latency(exp_name_q[0], exp_lat_q[0], waited);
                end
                void'(exp_act_q.pop_front());
                void'(exp_phv_q.pop_front());
                void'(exp_lat_q.pop_front());
                void'(exp_name_q.pop_front());
            end
        end
    end

    initial begin
        lookup_pkg::key_t keys[5];
        lookup_pkg::key_t mask;
        int               tbl;
        void'($urandom(32'h409b));
        rst_n        = 1'b0;
        extract_key  = '0;
        extract_mask = '0;
        key_valid    = 1'b0;
        phv_in       = '0;
        c_s_tdata    = '0;
        c_s_tuser    = '0;
        c_s_tkeep    = '0;
        c_s_tvalid   = 1'b0;
        c_s_tlast    = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            sh_key[i] = '0;
            sh_vld[i] = 1'b0;
            sh_act[i] = '0;
        end
        keys = '{32'ha0a0_0001, 32'ha0a0_0002, 32'h1234_5678, 32'ha0a0_0003, 32'hdead_beef};
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // empty table misses
        for (int i = 0; i < 3; i++) begin
            do_lookup("miss after reset", $urandom, $urandom & $urandom);
        end

        // all 16 actions from index 8 with wrap, then five keys from index 3
        val_q.delete();
        for (int i = 0; i < DEPTH; i++) begin
            val_q.push_back({$urandom, $urandom});
        end
        write_table("fill actions", 5, 8);
        val_q.delete();
        foreach (keys[i]) begin
            val_q.push_back({$urandom, keys[i]});
        end
        write_table("fill keys", 0, 3);
        foreach (keys[i]) begin
            do_lookup("exact hit", keys[i], '0);
        end

        // masked bits, lowest index wins
        do_lookup("mask low byte", 32'ha0a0_00ff, 32'h0000_00ff);
        do_lookup("mask bit0", 32'ha0a0_0002, 32'h0000_0001);
        do_lookup("mask nibble", 32'h1234_567f, 32'h0000_000f);
        do_lookup("masked miss", 32'hb0a0_0001, 32'h0000_00ff);

        // foreign packets pass through, tables untouched
        send_foreign("bad flag", make_hdr(16'hf2f0, STAGE, LKID, 0, 3), 3);
        send_foreign("bad stage", make_hdr(16'hf2f1, STAGE + 1, LKID, 0, 3), 2);
        send_foreign("bad lookup", make_hdr(16'hf2f1, STAGE, LKID + 1, 1, 3), 3);
        send_foreign("header only", make_hdr(16'h0000, STAGE, LKID, 0, 0), 0);
        foreach (keys[i]) begin
            do_lookup("after foreign", keys[i], '0);
        end

        // random writes mixed with lookups
        for (int it = 0; it < 60; it++) begin
            if ($urandom % 4 == 0) begin
                val_q.delete();
                for (int i = 0; i <= $urandom % 3; i++) begin
                    val_q.push_back({$urandom, $urandom});
                end
                tbl = ($urandom % 2) ? 0 : 1 + $urandom % 15;
                write_table("random write", tbl, $urandom % 256);
            end else begin
                mask = ($urandom % 2) ? '0 : $urandom & $urandom & $urandom;
                do_lookup("random lookup", sh_key[$urandom % DEPTH] ^ ($urandom & mask), mask);
            end
        end

        $display("errors: value mismatches %0d, other failures %0d", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== lookup_engine.sv ====
//**************************************************************************
// match-action lookup stage, top level
// key path searches the CAM and reads the action, control path fills tables
//**************************************************************************

`timescale 1ns/1ps

module lookup_engine #(
    parameter int STAGE_ID    = 0,
    parameter int LOOKUP_ID   = 2,
    parameter int TABLE_DEPTH = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  lookup_pkg::key_t    extract_key,
    input  lookup_pkg::key_t    extract_mask,
    input  logic                key_valid,
    input  lookup_pkg::phv_t    phv_in,
    output lookup_pkg::action_t action,
    output logic                action_valid,
    output lookup_pkg::phv_t    phv_out,
    input  ctrl_pkg::data_t     c_s_tdata,
    input  ctrl_pkg::user_t     c_s_tuser,
    input  ctrl_pkg::keep_t     c_s_tkeep,
    input  logic                c_s_tvalid,
    input  logic                c_s_tlast,
    output ctrl_pkg::data_t     c_m_tdata,
    output ctrl_pkg::user_t     c_m_tuser,
    output ctrl_pkg::keep_t     c_m_tkeep,
    output logic                c_m_tvalid,
    output logic                c_m_tlast
);
    lookup_pkg::action_t act_rd_data;

    tbl_wr_if #(.TABLE_DEPTH(TABLE_DEPTH)) wr_if ();
    cam_lookup_if #(.TABLE_DEPTH(TABLE_DEPTH)) lk_if ();

    ctrl_writer #(
        .STAGE_ID    (STAGE_ID),
        .LOOKUP_ID   (LOOKUP_ID),
        .TABLE_DEPTH (TABLE_DEPTH)
    ) ctrl_writer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .c_s_tdata  (c_s_tdata),
        .c_s_tuser  (c_s_tuser),
        .c_s_tkeep  (c_s_tkeep),
        .c_s_tvalid (c_s_tvalid),
        .c_s_tlast  (c_s_tlast),
        .c_m_tdata  (c_m_tdata),
        .c_m_tuser  (c_m_tuser),
        .c_m_tkeep  (c_m_tkeep),
        .c_m_tvalid (c_m_tvalid),
        .c_m_tlast  (c_m_tlast),
        .wr         (wr_if.writer)
    );

    key_cam #(.TABLE_DEPTH(TABLE_DEPTH)) key_cam_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr_if.cam),
        .lk    (lk_if.cam)
    );

    // read address is the registered match address
    action_ram #(.TABLE_DEPTH(TABLE_DEPTH)) action_ram_inst (
        .clk     (clk),
        .wr      (wr_if.ram),
        .rd_addr (lk_if.hit_addr),
        .rd_data (act_rd_data)
    );

    lookup_ctrl lookup_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .extract_key  (extract_key),
        .extract_mask (extract_mask),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .lk           (lk_if.requester),
        .rd_data      (act_rd_data),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out)
    );

endmodule

// ==== lookup_ctrl.sv ====
//**************************************************************************
// lookup FSM, issues the CAM search and merges hit or miss with the
// stored action and the captured PHV
//**************************************************************************

`timescale 1ns/1ps

module lookup_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lookup_pkg::key_t      extract_key,
    input  lookup_pkg::key_t      extract_mask,
    input  logic                  key_valid,
    input  lookup_pkg::phv_t      phv_in,
    cam_lookup_if.requester       lk,
    input  lookup_pkg::action_t   rd_data,
    output lookup_pkg::action_t   action,
    output logic                  action_valid,
    output lookup_pkg::phv_t      phv_out
);
    typedef enum logic [1:0] {S_IDLE, S_WAIT_MATCH, S_WAIT_READ, S_TRANSFER} lk_state_t;

    lk_state_t        state;
    lookup_pkg::phv_t phv_reg;

    // keys arriving mid-lookup are dropped
    assign lk.search = key_valid && (state == S_IDLE);
    assign lk.key    = extract_key;
    assign lk.mask   = extract_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            action_valid <= 1'b0;
        end else begin
            action_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (key_valid) begin
                        state <= S_WAIT_MATCH;
                    end
                end
                S_WAIT_MATCH: begin
                    if (lk.hit) begin
                        state <= S_WAIT_READ;
                    end else begin
                        // miss answers right away
                        action_valid <= 1'b1;
                        state        <= S_IDLE;
                    end
                end
                S_WAIT_READ: begin
                    action_valid <= 1'b1;
                    state        <= S_TRANSFER;
                end
                // stage stays busy while the hit action is on the outputs
                S_TRANSFER: state <= S_IDLE;
                default:    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lk.search) begin
            phv_reg <= phv_in;
        end
        if (state == S_WAIT_MATCH && !lk.hit) begin
            action  <= lookup_pkg::DEFAULT_ACTION;
            phv_out <= phv_reg;
        end
        if (state == S_WAIT_READ) begin
            action  <= rd_data;
            phv_out <= phv_reg;
        end
    end

    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) action_valid |=> !action_valid
    );

endmodule

// ==== action_ram.sv ====
//**************************************************************************
// action memory, write port from the control writer and a registered
// read port addressed by the CAM match address
//**************************************************************************

`timescale 1ns/1ps

module action_ram #(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                           clk,
    tbl_wr_if.ram                          wr,
    input  logic [$clog2(TABLE_DEPTH)-1:0] rd_addr,
    output lookup_pkg::action_t            rd_data
);
    lookup_pkg::action_t mem [TABLE_DEPTH];

    // write side
    always_ff @(posedge clk) begin
        if (wr.act_we) begin
            mem[wr.addr] <= wr.data[lookup_pkg::ACT_W-1:0];
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== key_cam.sv ====
//**************************************************************************
// ternary-compare key table, all entries searched in parallel
// result registered one cycle after the search strobe, lowest address wins
//**************************************************************************

`timescale 1ns/1ps

module key_cam #(
    parameter int TABLE_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    tbl_wr_if.cam      wr,
    cam_lookup_if.cam  lk
);
    localparam int ADDR_W = $clog2(TABLE_DEPTH);

    lookup_pkg::key_t       entry [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0] entry_vld;
    logic [TABLE_DEPTH-1:0] match;
    logic [ADDR_W-1:0]      first_addr;

    // masked compare, mask bit set means don't care
    always_comb begin
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            match[i] = entry_vld[i] && (((entry[i] ^ lk.key) & ~lk.mask) == '0);
        end
    end

    // priority encoder
    always_comb begin
        first_addr = '0;
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (match[i]) begin
                first_addr = ADDR_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.cam_we) begin
            entry[wr.addr] <= wr.data[lookup_pkg::KEY_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_vld   <= '0;
            lk.hit      <= 1'b0;
            lk.hit_addr <= '0;
        end else begin
            if (wr.cam_we) begin
                entry_vld[wr.addr] <= 1'b1;
            end
            if (lk.search) begin
                lk.hit      <= |match;
                lk.hit_addr <= first_addr;
            end
        end
    end

    // a reported hit always points at a written entry
    a_hit_entry_valid: assert property (
        @(posedge clk) disable iff (!rst_n) lk.hit |-> entry_vld[lk.hit_addr]
    );

endmodule

// ==== ctrl_writer.sv ====
//**************************************************************************
// control stream parser, consumes table writes addressed to this lookup
// and forwards every other packet one cycle later
//**************************************************************************

`timescale 1ns/1ps

module ctrl_writer #(
    parameter int STAGE_ID    = 0,
    parameter int LOOKUP_ID   = 2,
    parameter int TABLE_DEPTH = 16
) (
    input  logic            clk,
    input  logic            rst_n,
    input  ctrl_pkg::data_t c_s_tdata,
    input  ctrl_pkg::user_t c_s_tuser,
    input  ctrl_pkg::keep_t c_s_tkeep,
    input  logic            c_s_tvalid,
    input  logic            c_s_tlast,
    output ctrl_pkg::data_t c_m_tdata,
    output ctrl_pkg::user_t c_m_tuser,
    output ctrl_pkg::keep_t c_m_tkeep,
    output logic            c_m_tvalid,
    output logic            c_m_tlast,
    tbl_wr_if.writer        wr
);
    localparam int ADDR_W = $clog2(TABLE_DEPTH);

    ctrl_pkg::wr_state_t          state;
    logic [ADDR_W-1:0]            wr_idx;
    logic                         tbl_is_cam;
    logic                         hdr_ours;
    logic [ctrl_pkg::IDX_W-1:0]   hdr_idx;
    ctrl_pkg::data_t              beat_swapped;

    // header match on flag, stage id and lookup id
    assign hdr_ours =
        (c_s_tdata[ctrl_pkg::FLAG_LSB +: ctrl_pkg::FLAG_W] == ctrl_pkg::CTRL_FLAG) &&
        (c_s_tdata[ctrl_pkg::STAGE_LSB +: ctrl_pkg::STAGE_W] ==
            STAGE_ID[ctrl_pkg::STAGE_W-1:0]) &&
        (c_s_tdata[ctrl_pkg::LOOKUP_LSB +: ctrl_pkg::LOOKUP_W] ==
            LOOKUP_ID[ctrl_pkg::LOOKUP_W-1:0]);

    assign hdr_idx = c_s_tdata[ctrl_pkg::IDX_LSB +: ctrl_pkg::IDX_W];

    // entries travel little endian on the bus
    assign beat_swapped = {<<8{c_s_tdata}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ctrl_pkg::WR_IDLE;
            wr_idx     <= '0;
            tbl_is_cam <= 1'b0;
            wr.cam_we  <= 1'b0;
            wr.act_we  <= 1'b0;
            wr.addr    <= '0;
            c_m_tvalid <= 1'b0;
        end else begin
            wr.cam_we  <= 1'b0;
            wr.act_we  <= 1'b0;
            c_m_tvalid <= 1'b0;
            case (state)
                ctrl_pkg::WR_IDLE: begin
                    if (c_s_tvalid && hdr_ours) begin
                        tbl_is_cam <= (c_s_tdata[ctrl_pkg::TBL_LSB +: ctrl_pkg::TBL_W] ==
                                       ctrl_pkg::TBL_CAM);
                        // index wraps modulo table depth
                        wr_idx     <= hdr_idx[ADDR_W-1:0];
                        if (!c_s_tlast) begin
                            state <= ctrl_pkg::WR_WRITE;
                        end
                    end else if (c_s_tvalid) begin
                        c_m_tvalid <= 1'b1;
                        if (!c_s_tlast) begin
                            state <= ctrl_pkg::WR_FORWARD;
                        end
                    end
                end
                ctrl_pkg::WR_WRITE: begin
                    if (c_s_tvalid) begin
                        wr.cam_we <= tbl_is_cam;
                        wr.act_we <= !tbl_is_cam;
                        wr.addr   <= wr_idx;
                        wr_idx    <= wr_idx + 1'b1;
                        if (c_s_tlast) begin
                            state <= ctrl_pkg::WR_IDLE;
                        end
                    end
                end
                ctrl_pkg::WR_FORWARD: begin
                    if (c_s_tvalid) begin
                        c_m_tvalid <= 1'b1;
                        if (c_s_tlast) begin
                            state <= ctrl_pkg::WR_IDLE;
                        end
                    end
                end
                default: state <= ctrl_pkg::WR_IDLE;
            endcase
        end
    end

    // payload follows the bus every cycle, qualified by the strobes above
    always_ff @(posedge clk) begin
        wr.data   <= beat_swapped;
        c_m_tdata <= c_s_tdata;
        c_m_tuser <= c_s_tuser;
        c_m_tkeep <= c_s_tkeep;
        c_m_tlast <= c_s_tlast;
    end

    // strobes in adjacent cycles come from one packet and step through one table
    a_wr_consecutive: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr.cam_we || wr.act_we) ##1 (wr.cam_we || wr.act_we) |->
            (wr.addr == $past(wr.addr) + 1'b1) && (wr.cam_we == $past(wr.cam_we))
    );

endmodule

// ==== cam_lookup_if.sv ====
//**************************************************************************
// search request and registered match result between the lookup FSM
// and the CAM, hit_addr also addresses the action memory at the top level
//**************************************************************************

`timescale 1ns/1ps

interface cam_lookup_if #(
    parameter int TABLE_DEPTH = 16
);
    lookup_pkg::key_t               key;
    lookup_pkg::key_t               mask;
    logic                           search;
    logic                           hit;
    logic [$clog2(TABLE_DEPTH)-1:0] hit_addr;

    modport requester (output key, mask, search, input hit);
    modport cam       (input key, mask, search, output hit, hit_addr);
endinterface

// ==== tbl_wr_if.sv ====
//**************************************************************************
// table write port shared by the CAM and the action memory
// driven by the control writer, data holds the byte-swapped beat
//**************************************************************************

`timescale 1ns/1ps

interface tbl_wr_if #(
    parameter int TABLE_DEPTH = 16
);
    logic                           cam_we;
    logic                           act_we;
    logic [$clog2(TABLE_DEPTH)-1:0] addr;
    ctrl_pkg::data_t                data;

    modport writer (output cam_we, act_we, addr, data);
    modport cam    (input cam_we, addr, data);
    modport ram    (input act_we, addr, data);
endinterface

// ==== ctrl_pkg.sv ====
//**************************************************************************
// control stream definitions used by the table writer
// bus widths, header field positions in the raw beat and writer states
//**************************************************************************

package ctrl_pkg;

    localparam int DATA_W = 64;
    localparam int USER_W = 16;
    localparam int KEEP_W = DATA_W / 8;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [USER_W-1:0] user_t;
    typedef logic [KEEP_W-1:0] keep_t;

    // marks a table write packet
    localparam logic [15:0] CTRL_FLAG = 16'hf2f1;

    // header positions, raw beat without byte swap
    localparam int FLAG_LSB   = 0;
    localparam int FLAG_W     = 16;
    localparam int LOOKUP_LSB = 16;
    localparam int LOOKUP_W   = 3;
    localparam int STAGE_LSB  = 19;
    localparam int STAGE_W    = 5;
    localparam int TBL_LSB    = 24;
    localparam int TBL_W      = 4;
    localparam int IDX_LSB    = 32;
    localparam int IDX_W      = 8;

    // any other code selects the action table
    localparam logic [TBL_W-1:0] TBL_CAM = 4'd0;

    typedef enum logic [1:0] {WR_IDLE, WR_WRITE, WR_FORWARD} wr_state_t;

endpackage

// ==== lookup_pkg.sv ====
//**************************************************************************
// lookup datapath definitions for the match-action stage
// key, mask, action and PHV widths plus the action returned on a miss
//**************************************************************************

package lookup_pkg;

    // key and mask width
    localparam int KEY_W = 32;

    // action entry width
    localparam int ACT_W = 48;

    // packet header vector width
    localparam int PHV_W = 64;

    // a mask bit of 1 means don't care
    typedef logic [KEY_W-1:0] key_t;

    typedef logic [ACT_W-1:0] action_t;

    typedef logic [PHV_W-1:0] phv_t;

    // returned whenever the CAM misses
    localparam action_t DEFAULT_ACTION = action_t'(48'h3f);

endpackage
